// File: compile.f
hw/cp0_pkg.sv
hw/cp0_exe_if.sv
hw/cp0_exe_stage.sv
hw/irq_sync.sv
hw/cp0_regs.sv
hw/cp0_redirect.sv
hw/cp0_top.sv
verif/cp0_chk.sv
verif/cp0_tb.sv

// File: Makefile
# Verilator simulation of the CP0 testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module cp0_tb -f compile.f -o cp0_sim

# pass only if the log holds the pass line
run: compile
	./obj_dir/cp0_sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb;
    localparam logic [31:0] PRID_RESET = 32'h2002_1125;
    localparam logic [31:0] EXC_VECTOR = 32'h0000_4180;
    localparam int          IRQ_STAGES = 2;
    localparam logic [31:0] ERET       = 32'h4200_0018;
    localparam int          DRAIN_MAX  = 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_delay;
    logic [4:0]  exc_code;
    logic [31:0] wdata;
    logic [5:0]  irq;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        rdata_valid;
    logic [31:0] rdata;

    // model of the execute stage, the irq delay line and the registers
    logic        m_valid;
    logic        m_dly;
    logic [4:0]  m_code;
    logic [31:0] m_instr;
    logic [31:0] m_pc;
    logic [31:0] m_wdata;
    logic [31:0] m_status;
    logic [31:0] m_cause;
    logic [31:0] m_epc;
    logic [31:0] m_prid;
    logic [5:0]  m_sync [IRQ_STAGES];
    logic [31:0] redir_q [$];
    logic [31:0] read_q [$];
    logic [31:0] rng = 32'h40db_ae15;
    string       test_name = "reset_values";

    cp0_top #(
        .PRID_RESET (PRID_RESET),
        .EXC_VECTOR (EXC_VECTOR),
        .IRQ_STAGES (IRQ_STAGES)
    ) cp0_top_inst (.*);

    bind cp0_top cp0_chk #(.EXC_VECTOR(EXC_VECTOR)) cp0_chk_inst (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rdata_valid    (rdata_valid)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] mtc0_word(input logic [4:0] sel);
        return {6'b010000, 5'b00100, 5'd0, sel, 11'd0};
    endfunction

    function automatic logic [31:0] mfc0_word(input logic [4:0] sel);
        return {6'b010000, 5'b00000, 5'd0, sel, 11'd0};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_run("mismatch between DUT and reference model");
        end
    endtask

    // one step of the rules on the instruction in execute
    function automatic void cp0_model(input logic iv, input logic [31:0] word,
                                      input logic [31:0] at_pc, input logic dly,
                                      input logic [4:0] code, input logic [31:0] data,
                                      input logic [5:0] lines);
        logic        irq_t;
        logic        exc_t;
        logic        eret_t;
        logic        keep_ip;
        logic [31:0] rd;
        irq_t   = m_valid && |(m_cause[15:10] & m_status[15:10]) && m_status[0] && !m_status[1];
        exc_t   = m_valid && !irq_t && !m_status[1] && (m_code inside {5'd4, 5'd5, 5'd10, 5'd12});
        eret_t  = m_valid && !irq_t && !exc_t && (m_instr == ERET);
        keep_ip = 1'b0;
        case (m_instr[15:11])
            5'd12:   rd = m_status;
            5'd13:   rd = m_cause;
            5'd14:   rd = m_epc;
            5'd15:   rd = m_prid;
            default: rd = 32'hffff_ffff;
        endcase
        if (irq_t || exc_t) begin
            redir_q.push_back(EXC_VECTOR);
            m_epc        = m_dly ? m_pc - 32'd4 : m_pc;
            m_cause[31]  = m_dly;
            m_cause[6:2] = irq_t ? 5'd0 : m_code;
            m_status[1]  = 1'b1;
        end else if (eret_t) begin
            redir_q.push_back({m_epc[31:2], 2'b00});
            m_status[1] = 1'b0;
        end else if (m_valid && m_instr[31:21] == 11'b010000_00100) begin
            case (m_instr[15:11])
                5'd12:   m_status = m_wdata;
                5'd13:   m_cause = m_wdata;
                5'd14:   m_epc = m_wdata;
                5'd15:   m_prid = m_wdata;
                default: ;
            endcase
            keep_ip = (m_instr[15:11] == 5'd13);
        end else if (m_valid && m_instr[31:21] == 11'b010000_00000) begin
            read_q.push_back(rd);
        end
        if (!keep_ip)
            m_cause[15:10] = m_sync[IRQ_STAGES-1];
        for (int i = IRQ_STAGES - 1; i > 0; i--)
            m_sync[i] = m_sync[i-1];
        m_sync[0] = lines;
        m_valid   = iv && !(irq_t || exc_t || eret_t); // squash behind a redirect
        m_instr   = word;
        m_pc      = at_pc;
        m_dly     = dly;
        m_code    = code;
        m_wdata   = data;
    endfunction

    // outputs sampled at the edge before the flops update
    always @(posedge clk) begin
        if (reset) begin
            m_valid  = 1'b0;
            m_status = 32'd0;
            m_cause  = 32'd0;
            m_epc    = 32'd0;
            m_prid   = PRID_RESET;
            for (int i = 0; i < IRQ_STAGES; i++)
                m_sync[i] = 6'd0;
            redir_q.delete();
            read_q.delete();
        end else begin
            if (redirect_valid) begin
                if (redir_q.size() == 0)
                    stop_run("DUT redirected when no redirect was expected");
                check_value("redirect_pc", redir_q.pop_front(), redirect_pc);
            end else if (redir_q.size() != 0) begin
                stop_run("expected redirect did not happen");
            end
            if (rdata_valid) begin
                if (read_q.size() == 0)
                    stop_run("DUT returned read data when no mfc0 was expected");
                check_value("rdata", read_q.pop_front(), rdata);
            end else if (read_q.size() != 0) begin
                stop_run("expected mfc0 result did not arrive");
            end
            cp0_model(instr_valid, instr, pc, is_delay, exc_code, wdata, irq);
        end
    end

    task automatic issue(input logic [31:0] word, input logic [31:0] at_pc, input logic dly,
                         input logic [4:0] code, input logic [31:0] data);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= at_pc;
        is_delay    <= dly;
        exc_code    <= code;
        wdata       <= data;
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic set_irq(input logic [5:0] lines);
        @(posedge clk);
        instr_valid <= 1'b0;
        irq         <= lines;
    endtask

    // wait until execute is empty and every expected result was seen
    task automatic settle();
        int waited;
        waited = 0;
        idle(1);
        do begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_MAX)
                stop_run("timeout waiting for outstanding results to drain");
        end while (m_valid || redir_q.size() != 0 || read_q.size() != 0);
    endtask

    task automatic write_read(input logic [4:0] sel);
        issue(mtc0_word(sel), next_rand(), 1'b0, 5'd0, next_rand());
        issue(mfc0_word(sel), next_rand(), 1'b0, 5'd0, 32'd0);
        settle();
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        is_delay    = 1'b0;
        exc_code    = 5'd0;
        wdata       = 32'd0;
        irq         = 6'd0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        issue(mfc0_word(5'd15), 32'h100, 1'b0, 5'd0, 32'd0);
        issue(mfc0_word(5'd3), 32'h104, 1'b0, 5'd0, 32'd0);    // unmapped select
        settle();

        test_name = "mtc0_mfc0";
        write_read(5'd12);
        write_read(5'd14);
        write_read(5'd15);
        issue(mtc0_word(5'd12), next_rand(), 1'b0, 5'd0, 32'd0);
        settle();

        test_name = "exception";
        issue(32'd0, next_rand(), 1'b0, 5'd10, 32'd0);              // RI
        issue(mtc0_word(5'd14), next_rand(), 1'b0, 5'd0, next_rand()); // must be squashed
        settle();
        issue(mfc0_word(5'd14), next_rand(), 1'b0, 5'd0, 32'd0);
        issue(mfc0_word(5'd13), next_rand(), 1'b0, 5'd0, 32'd0);
        issue(mfc0_word(5'd12), next_rand(), 1'b0, 5'd0, 32'd0);
        settle();
        issue(32'd0, next_rand(), 1'b0, 5'd12, 32'd0);            // ignored while EXL is set
        settle();
        issue(ERET, next_rand(), 1'b0, 5'd0, 32'd0);
        settle();
        issue(32'd0, next_rand(), 1'b1, 5'd12, 32'd0);            // Ov in a delay slot
        settle();
        issue(mfc0_word(5'd14), next_rand(), 1'b0, 5'd0, 32'd0);
        issue(mfc0_word(5'd13), next_rand(), 1'b0, 5'd0, 32'd0);
        issue(ERET, next_rand(), 1'b0, 5'd0, 32'd0);
        settle();

        test_name = "interrupt";
        issue(mtc0_word(5'd12), next_rand(), 1'b0, 5'd0, 32'h0000_1001); // IE and line 2 unmasked
        settle();
        set_irq(6'b000100);
        idle(IRQ_STAGES + 2);
        issue(32'd0, next_rand(), 1'b0, 5'd0, 32'd0);
        settle();
        set_irq(6'd0);
        idle(IRQ_STAGES + 2);
        issue(mfc0_word(5'd13), next_rand(), 1'b0, 5'd0, 32'd0);
        issue(ERET, next_rand(), 1'b0, 5'd0, 32'd0);
        settle();

        test_name = "masked_irq";
        set_irq(6'b001000);
        idle(IRQ_STAGES + 2);
        issue(32'd0, next_rand(), 1'b0, 5'd0, 32'd0);
        issue(mfc0_word(5'd13), next_rand(), 1'b0, 5'd0, 32'd0);
        settle();
        set_irq(6'd0);
        settle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verif/cp0_chk.sv
`timescale 1ns/1ps

module cp0_chk #(
    parameter logic [31:0] EXC_VECTOR = 32'h0000_4180
) (
    input logic        clk,
    input logic        reset,
    input logic        redirect_valid,
    input logic [31:0] redirect_pc,
    input logic        rdata_valid
);

    // redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid stayed high for two cycles");

    reset_quiet: assert property (@(posedge clk)
        reset |=> (!redirect_valid && !rdata_valid))
        else $error("redirect_valid or rdata_valid high right after reset");

    // eret targets are word aligned
    redirect_target: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> (redirect_pc == EXC_VECTOR || redirect_pc[1:0] == 2'b00))
        else $error("redirect_pc is neither the vector nor word aligned");

endmodule

// File: hw/cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
    parameter logic [31:0] PRID_RESET = 32'h2002_1125,
    parameter logic [31:0] EXC_VECTOR = 32'h0000_4180,
    parameter int          IRQ_STAGES = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic        is_delay,
    input  logic [4:0]  exc_code,
    input  logic [31:0] wdata,
    input  logic [5:0]  irq,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        rdata_valid,
    output logic [31:0] rdata
);

    logic        take;
    logic        take_exc;
    logic [31:0] target_pc;
    logic [5:0]  irq_synced;

    cp0_exe_if exe_bus ();

    cp0_exe_stage cp0_exe_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .is_delay    (is_delay),
        .exc_code    (exc_code),
        .wdata       (wdata),
        .squash      (take),
        .exe         (exe_bus.producer)
    );

    irq_sync #(
        .IRQ_STAGES (IRQ_STAGES)
    ) irq_sync_inst (
        .clk     (clk),
        .reset   (reset),
        .irq_in  (irq),
        .irq_out (irq_synced)
    );

    cp0_regs #(
        .PRID_RESET (PRID_RESET)
    ) cp0_regs_inst (
        .clk         (clk),
        .reset       (reset),
        .irq_pending (irq_synced),
        .exe         (exe_bus.consumer),
        .take        (take),
        .take_exc    (take_exc),
        .target_pc   (target_pc),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

    cp0_redirect #(
        .EXC_VECTOR (EXC_VECTOR)
    ) cp0_redirect_inst (
        .clk            (clk),
        .reset          (reset),
        .take           (take),
        .take_exc       (take_exc),
        .target_pc      (target_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: hw/cp0_redirect.sv
`timescale 1ns/1ps

module cp0_redirect #(
    parameter logic [31:0] EXC_VECTOR = 32'h0000_4180
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        take,
    input  logic        take_exc,
    input  logic [31:0] target_pc,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic [31:0] next_pc;

    // vector for interrupts and exceptions, saved epc for eret
    assign next_pc = take_exc ? EXC_VECTOR : target_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take; // one cycle, take never holds two in a row
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_pc <= EXC_VECTOR;
        end else if (take) begin
            redirect_pc <= next_pc;
        end
    end

endmodule

// File: hw/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
    parameter logic [31:0] PRID_RESET = 32'h2002_1125
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  irq_pending,
    cp0_exe_if.consumer exe,
    output logic        take,
    output logic        take_exc,
    output logic [31:0] target_pc,
    output logic        rdata_valid,
    output logic [31:0] rdata
);
    import cp0_pkg::*;

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] prid_q;

    logic        irq_hit;
    logic        exc_known;
    logic        exc_hit;
    logic        eret_hit;
    logic        mtc0_hit;
    logic        mfc0_hit;
    logic [31:0] epc_next;
    logic [31:0] read_mux;

    assign irq_hit = exe.valid
                  && (|(cause_q[IP_MSB:IP_LSB] & status_q[IM_MSB:IM_LSB]))
                  && status_q[STATUS_IE]
                  && !status_q[STATUS_EXL];

    assign exc_known = exe.exc inside {exc_adel, exc_ades, exc_ri, exc_ov};
    // exceptions under EXL are dropped, the instruction runs on
    assign exc_hit   = exe.valid && !irq_hit && exc_known && !status_q[STATUS_EXL];
    assign eret_hit  = exe.valid && !irq_hit && !exc_hit && (exe.op == op_eret);

    assign take_exc = irq_hit || exc_hit;
    assign take     = take_exc || eret_hit;
    assign mtc0_hit = exe.valid && !take && (exe.op == op_mtc0);
    assign mfc0_hit = exe.valid && !take && (exe.op == op_mfc0);

    assign epc_next  = exe.is_delay ? exe.pc - 32'd4 : exe.pc; // back up to the branch
    assign target_pc = {epc_q[31:2], 2'b00};

    always_comb begin
        case (exe.sel)
            reg_status: read_mux = status_q;
            reg_cause:  read_mux = cause_q;
            reg_epc:    read_mux = epc_q;
            reg_prid:   read_mux = prid_q;
            default:    read_mux = UNMAPPED_READ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q    <= 32'd0;
            cause_q     <= 32'd0;
            epc_q       <= 32'd0;
            prid_q      <= PRID_RESET;
            rdata_valid <= 1'b0;
        end else begin
            cause_q[IP_MSB:IP_LSB] <= irq_pending; // an mtc0 to cause overrides below
            rdata_valid <= mfc0_hit;

            if (take_exc) begin
                epc_q                            <= epc_next;
                cause_q[CAUSE_BD]                <= exe.is_delay;
                cause_q[EXCCODE_MSB:EXCCODE_LSB] <= irq_hit ? exc_int : exe.exc;
                status_q[STATUS_EXL]             <= 1'b1;
            end else if (eret_hit) begin
                status_q[STATUS_EXL] <= 1'b0;
            end else if (mtc0_hit) begin
                case (exe.sel)
                    reg_status: status_q <= exe.wdata;
                    reg_cause:  cause_q  <= exe.wdata;
                    reg_epc:    epc_q    <= exe.wdata;
                    reg_prid:   prid_q   <= exe.wdata;
                    default:    ;   // unmapped, ignored
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mfc0_hit) begin
            rdata <= read_mux;
        end
    end

endmodule

// File: hw/irq_sync.sv
`timescale 1ns/1ps

module irq_sync #(
    parameter int IRQ_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] irq_in,
    output logic [5:0] irq_out
);

    logic [5:0] ranks [IRQ_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < IRQ_STAGES; i++) begin
                ranks[i] <= 6'd0;
            end
        end else begin
            ranks[0] <= irq_in;
            for (int i = 1; i < IRQ_STAGES; i++) begin
                ranks[i] <= ranks[i-1];
            end
        end
    end

    assign irq_out = ranks[IRQ_STAGES-1];

endmodule

// File: hw/cp0_exe_stage.sv
`timescale 1ns/1ps

module cp0_exe_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic        is_delay,
    input  logic [4:0]  exc_code,
    input  logic [31:0] wdata,
    input  logic        squash,
    cp0_exe_if.producer exe
);
    import cp0_pkg::*;

    cp0_op_t op_d;

    // decode ahead of the stage register
    always_comb begin
        op_d = op_none;
        if (instr == ERET_WORD) begin
            op_d = op_eret;
        end else if (instr[31:21] == MTC0_PATTERN) begin
            op_d = op_mtc0;
        end else if (instr[31:21] == MFC0_PATTERN) begin
            op_d = op_mfc0;
        end
    end

    // instruction behind a redirect never enters execute
    always_ff @(posedge clk) begin
        if (reset) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= instr_valid && !squash;
        end
    end

    always_ff @(posedge clk) begin
        exe.op       <= op_d;
        exe.sel      <= instr[15:11];
        exe.exc      <= exc_code_t'(exc_code);
        exe.pc       <= pc;
        exe.is_delay <= is_delay;
        exe.wdata    <= wdata;
    end

endmodule

// File: hw/cp0_exe_if.sv
`timescale 1ns/1ps

interface cp0_exe_if;
    import cp0_pkg::*;

    logic        valid;
    cp0_op_t     op;
    logic [4:0]  sel;       // raw rd field
    exc_code_t   exc;
    logic [31:0] pc;
    logic        is_delay;
    logic [31:0] wdata;

    modport producer (
        output valid,
        output op,
        output sel,
        output exc,
        output pc,
        output is_delay,
        output wdata
    );

    modport consumer (
        input valid,
        input op,
        input sel,
        input exc,
        input pc,
        input is_delay,
        input wdata
    );

endinterface

// File: hw/cp0_pkg.sv
package cp0_pkg;

    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_mtc0 = 2'd1,
        op_mfc0 = 2'd2,
        op_eret = 2'd3
    } cp0_op_t;

    // rd field of mtc0/mfc0, anything else reads as unmapped
    typedef enum logic [4:0] {
        reg_status = 5'd12,
        reg_cause  = 5'd13,
        reg_epc    = 5'd14,
        reg_prid   = 5'd15
    } cp0_reg_t;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exc_code_t;

    localparam logic [10:0] MTC0_PATTERN = 11'b010000_00100; // cop0, rs = mt
    localparam logic [10:0] MFC0_PATTERN = 11'b010000_00000; // cop0, rs = mf
    localparam logic [31:0] ERET_WORD    = 32'h4200_0018;

    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int IM_LSB     = 10;
    localparam int IM_MSB     = 15;

    localparam int CAUSE_BD    = 31;
    localparam int IP_LSB      = 10;
    localparam int IP_MSB      = 15;
    localparam int EXCCODE_LSB = 2;
    localparam int EXCCODE_MSB = 6;

    localparam logic [31:0] UNMAPPED_READ = 32'hffff_ffff;

endpackage
